// File: Makefile
VERILATOR ?= verilator
TOP       ?= pwl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/pwl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_chk (
	input logic clk,
	input logic arst_n,
	input logic halt,
	input logic dma_ready,
	input logic valid_batch
);
	int fail_cnt = 0;

	a_no_load_in_batch: assert property (@(posedge clk) disable iff (!arst_n)
		valid_batch |-> !dma_ready)
		else begin
			fail_cnt++;
			$error("dma_ready high while valid_batch pulses");
		end

	a_halt_to_idle: assert property (@(posedge clk) disable iff (!arst_n)
		halt |=> dma_ready)
		else begin
			fail_cnt++;
			$error("dma_ready not high one cycle after halt");
		end

	a_batch_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		valid_batch |=> !valid_batch)
		else begin
			fail_cnt++;
			$error("valid_batch high in two consecutive cycles");
		end

endmodule

`default_nettype wire

// File: dv/pwl_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pwl_clk_gen (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/pwl_monitor.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_monitor (
	input  logic                      clk,
	input  logic                      arst_n,
	input  pwl_stream_pkg::dma_word_t dma_data,
	input  logic                      dma_valid,
	input  logic                      dma_last,
	input  logic                      run_pwl,
	input  logic                      halt,
	input  logic                      dma_ready,
	input  logic                      valid_batch,
	input  pwl_wave_pkg::batch_t      batch,
	output int                        value_errs,
	output int                        proto_errs
);
	import pwl_stream_pkg::*;
	import pwl_wave_pkg::*;

	pwl_state_t st, st_nxt;
	dma_word_t  tab [`PWL_MAX_SEGS];
	int         cnt, pos;
	logic       run_d1, run_d2, rdy_exp, take;
	sample_t    wave [$];

	// one period of the expected wave.
	function automatic void build_wave();
		seg_word_t w;
		int        n;
		longint    v;
		wave.delete();
		for (int s = 0; s < cnt; s++) begin
			w = seg_word_t'(tab[s]);
			n = (w.len == 0) ? 1 : int'(w.len); // zero length plays once.
			for (int k = 0; k < n; k++) begin
				v = longint'(w.start) + ((longint'(w.slope) * k) >>> `PWL_FRAC);
				wave.push_back(sample_t'(v[15:0]));
			end
		end
	endfunction

	task automatic check_batch();
		sample_t e;
		for (int i = 0; i < `PWL_BATCH; i++) begin
			e = wave[(pos + i) % wave.size()];
			if (batch[i] !== e) begin
				value_errs++;
				$display("CHECK FAILED batch lane %0d: expected %h, got %h", i, e, batch[i]);
			end
		end
		pos += `PWL_BATCH;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st         = IDLE;
			cnt        = 0;
			pos        = 0;
			run_d1     = 1'b0;
			run_d2     = 1'b0;
			value_errs = 0;
			proto_errs = 0;
		end else begin
			rdy_exp = (st == IDLE) || (st == LOAD);
			if (dma_ready !== rdy_exp) begin
				proto_errs++;
				$display("CHECK FAILED dma_ready: expected %h, got %h", rdy_exp, dma_ready);
			end
			// a batch closes two cycles after its last step.
			if (valid_batch && !(run_d1 && run_d2)) begin
				proto_errs++;
				$display("valid_batch pulsed while the generator was not running");
			end else if (valid_batch) begin
				check_batch();
			end
			take   = dma_valid && rdy_exp;
			st_nxt = st;
			case (st)
				IDLE: if (take) st_nxt = dma_last ? READY : LOAD;
				LOAD: if (take && dma_last) st_nxt = READY;
				READY: if (run_pwl) st_nxt = RUN;
				RUN: if (!run_pwl) st_nxt = READY;
			endcase
			if (halt) begin
				st_nxt = IDLE;
				cnt    = 0;
			end else if (take && cnt < `PWL_MAX_SEGS) begin
				tab[cnt] = dma_data;
				cnt++;
			end
			if (st_nxt == RUN && st != RUN) begin
				build_wave();
				pos = 0; // every run starts at sample 0.
			end
			run_d2 = run_d1;
			run_d1 = (st == RUN);
			st     = st_nxt;
		end
	end

endmodule

`default_nettype wire

// File: dv/pwl_tb.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_tb;
	import pwl_stream_pkg::*;
	import pwl_wave_pkg::*;

	localparam int  N_TESTS  = 6;
	localparam int  TEST_CYC = 20 * 7 + 48 * `PWL_BATCH + 40; // words and gaps, run, margin.
	localparam real LIMIT_NS = N_TESTS * TEST_CYC * 40.0;

	logic      clk, arst_n;
	dma_word_t dma_data;
	logic      dma_valid, dma_last, run_pwl, halt;
	logic      dma_ready, valid_batch;
	batch_t    batch;
	int        value_errs, proto_errs, stall_errs;

	pwl_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

	pwl_gen_top dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.dma_data    (dma_data),
		.dma_valid   (dma_valid),
		.dma_last    (dma_last),
		.run_pwl     (run_pwl),
		.halt        (halt),
		.dma_ready   (dma_ready),
		.valid_batch (valid_batch),
		.batch       (batch)
	);

	pwl_monitor u_mon (
		.clk(clk), .arst_n(arst_n), .dma_data(dma_data), .dma_valid(dma_valid),
		.dma_last(dma_last), .run_pwl(run_pwl), .halt(halt), .dma_ready(dma_ready),
		.valid_batch(valid_batch), .batch(batch),
		.value_errs(value_errs), .proto_errs(proto_errs)
	);

	bind pwl_gen_top pwl_chk u_chk (
		.clk(clk), .arst_n(arst_n), .halt(halt), .dma_ready(dma_ready),
		.valid_batch(valid_batch)
	);

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic dma_word_t rand_word(int max_len);
		seg_word_t w;
		w.rsvd  = 16'($urandom);
		w.len   = 16'($urandom % (max_len + 1));
		w.slope = 16'($urandom);
		w.start = 16'($urandom);
		return dma_word_t'(w);
	endfunction

	// loads n words with random gaps and returns the playback period.
	task automatic load_table(int n, int max_len, output int period);
		seg_word_t w;
		int        tries;
		period = 0;
		for (int i = 0; i < n; i++) begin
			dma_valid = 1'b0;
			repeat ($urandom % 6) next_cycle();
			dma_data  = rand_word((i == 2) ? 0 : max_len);
			dma_last  = (i == n - 1);
			dma_valid = 1'b1;
			tries     = 0;
			while (!dma_ready && tries < 20) begin
				next_cycle();
				tries++;
			end
			if (!dma_ready) begin
				stall_errs++;
				$display("load word %0d was never accepted", i);
			end
			w = seg_word_t'(dma_data);
			if (i < `PWL_MAX_SEGS) period += (w.len == 0) ? 1 : int'(w.len);
			next_cycle();
		end
		dma_valid = 1'b0;
		dma_last  = 1'b0;
	endtask

	// runs for n batches, then stops stop_lane cycles after the last one.
	task automatic play(int n, int stop_lane, bit use_halt);
		int seen;
		int waited;
		seen     = 0;
		waited   = 0;
		run_pwl  = 1'b1;
		while (seen < n && waited < n * 8 + 40) begin
			next_cycle();
			waited++;
			if (valid_batch) seen++;
		end
		if (seen < n) begin
			stall_errs++;
			$display("only %0d of %0d batches appeared", seen, n);
		end
		repeat (stop_lane) next_cycle();
		if (use_halt) halt = 1'b1;
		else run_pwl = 1'b0;
		next_cycle();
		halt    = 1'b0;
		run_pwl = 1'b0;
	endtask

	task automatic pulse_halt();
		halt = 1'b1;
		next_cycle();
		halt = 1'b0;
	endtask

	initial begin
		int period;
		dma_data   = '0;
		dma_valid  = 1'b0;
		dma_last   = 1'b0;
		run_pwl    = 1'b0;
		halt       = 1'b0;
		stall_errs = 0;
		void'($urandom(32'hfc40));
		@(posedge arst_n);
		next_cycle();
		load_table(1, 9, period);
		dma_data  = rand_word(4); // offered while ready is low.
		dma_valid = 1'b1;
		repeat (3) next_cycle();
		dma_valid = 1'b0;
		play((4 * period + 3) / 4 + 2, 0, 1'b0);
		pulse_halt();
		load_table(6, 9, period);
		play((3 * period) / 4 + 2, 2, 1'b0); // drop mid batch.
		play(8, 1, 1'b0);
		pulse_halt();
		load_table(20, 5, period);
		play((2 * period) / 4 + 2, 0, 1'b0);
		play(6, 1, 1'b1);
		load_table(4, 9, period);
		play((3 * period) / 4 + 2, 0, 1'b0);
		repeat (4) next_cycle();
		$display("value errors %0d, protocol errors %0d, stalls %0d, assertion failures %0d",
			value_errs, proto_errs, stall_errs, dut.u_chk.fail_cnt);
		if (value_errs + proto_errs + stall_errs + dut.u_chk.fail_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout: the test sequence did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/pwl_stream_pkg.sv
source/pwl_wave_pkg.sv
source/pwl_step_if.sv
source/pwl_ctrl.sv
source/pwl_seg_timer.sv
source/pwl_sample_gen.sv
source/pwl_gen_top.sv
dv/pwl_clk_gen.sv
dv/pwl_monitor.sv
dv/pwl_chk.sv
dv/pwl_tb.sv

// File: source/pwl_consts.svh
`ifndef PWL_CONSTS_SVH
`define PWL_CONSTS_SVH

`default_nettype none

`define PWL_DMA_W    64  // stream word.
`define PWL_SAMPLE_W 16
`define PWL_BATCH    4   // lanes per batch.
`define PWL_MAX_SEGS 16
`define PWL_FRAC     8   // slope fraction bits.
`define PWL_LEN_W    16

// segment count runs 0 to max inclusive.
`define PWL_CNT_W    ($clog2(`PWL_MAX_SEGS) + 1)

`default_nettype wire

`endif

// File: source/pwl_ctrl.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_ctrl (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    dma_valid,
	input  logic                    dma_last,
	input  logic                    run_pwl,
	input  logic                    halt,
	output logic                    dma_ready,
	output logic                    wr_en,
	output pwl_stream_pkg::seg_idx_t wr_idx,
	output logic [`PWL_CNT_W-1:0]   seg_count,
	output logic                    running
);
	import pwl_stream_pkg::*;
	import pwl_wave_pkg::*;

	pwl_state_t state, state_nxt;
	logic       accept;

	assign dma_ready = (state == IDLE) || (state == LOAD);
	assign accept    = dma_valid && dma_ready;
	// words past the table depth are taken but dropped.
	assign wr_en     = accept && !halt && (seg_count < `PWL_MAX_SEGS);
	assign wr_idx    = seg_count[$bits(seg_idx_t)-1:0];
	assign running   = (state == RUN);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (accept) state_nxt = dma_last ? READY : LOAD;
			LOAD: if (accept && dma_last) state_nxt = READY;
			READY: if (run_pwl) state_nxt = RUN;
			RUN: if (!run_pwl) state_nxt = READY;
			default: state_nxt = IDLE;
		endcase
		if (halt) state_nxt = IDLE; // halt wins over everything.
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			seg_count <= '0;
		end else begin
			state <= state_nxt;
			if (halt) begin
				seg_count <= '0;
			end else if (wr_en) begin
				seg_count <= seg_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pwl_gen_top.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_gen_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  pwl_stream_pkg::dma_word_t dma_data,
	input  logic                      dma_valid,
	input  logic                      dma_last,
	input  logic                      run_pwl,
	input  logic                      halt,
	output logic                      dma_ready,
	output logic                      valid_batch,
	output pwl_wave_pkg::batch_t      batch
);
	import pwl_stream_pkg::*;

	logic                  wr_en;
	seg_idx_t              wr_idx;
	logic [`PWL_CNT_W-1:0] seg_count;
	logic                  running;

	pwl_step_if step_bus ();

	pwl_ctrl u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.dma_valid (dma_valid),
		.dma_last  (dma_last),
		.run_pwl   (run_pwl),
		.halt      (halt),
		.dma_ready (dma_ready),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.seg_count (seg_count),
		.running   (running)
	);

	pwl_seg_timer u_timer (
		.clk       (clk),
		.arst_n    (arst_n),
		.running   (running),
		.seg_count (seg_count),
		.step_if   (step_bus.timer)
	);

	pwl_sample_gen #(.LANES(`PWL_BATCH)) u_gen (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_en       (wr_en),
		.wr_idx      (wr_idx),
		.wr_data     (dma_data),
		.step_if     (step_bus.gen),
		.valid_batch (valid_batch),
		.batch       (batch)
	);

endmodule

`default_nettype wire

// File: source/pwl_sample_gen.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_sample_gen #(
	parameter int LANES = `PWL_BATCH
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      wr_en,
	input  pwl_stream_pkg::seg_idx_t  wr_idx,
	input  pwl_stream_pkg::dma_word_t wr_data,
	pwl_step_if.gen                   step_if,
	output logic                      valid_batch,
	output pwl_wave_pkg::batch_t      batch
);
	import pwl_stream_pkg::*;
	import pwl_wave_pkg::*;

	localparam int ACC_W = 32;
	localparam int CW    = $clog2(LANES);
	localparam int EXT_W = ACC_W - `PWL_SAMPLE_W - `PWL_FRAC;
	localparam logic [CW-1:0] LAST_LANE = CW'(LANES - 1);

	seg_word_t               seg_tab [`PWL_MAX_SEGS];
	seg_word_t               cur;
	logic signed [ACC_W-1:0] acc;
	sample_t                 sample;
	sample_t [LANES-1:0]     lanes;
	logic [CW-1:0]           lane_cnt;
	logic                    sample_vld;

	assign cur             = seg_tab[step_if.seg_idx];
	assign step_if.seg_len = cur.len;
	assign sample          = acc[`PWL_FRAC +: `PWL_SAMPLE_W]; // integer part.
	assign batch           = lanes;

	always_ff @(posedge clk) begin
		if (wr_en) seg_tab[wr_idx] <= seg_word_t'(wr_data);
	end

	always_ff @(posedge clk) begin
		if (step_if.step) begin
			if (step_if.seg_first) begin
				acc <= {{EXT_W{cur.start[`PWL_SAMPLE_W-1]}}, cur.start, {`PWL_FRAC{1'b0}}};
			end else begin
				acc <= acc + {{(ACC_W - 16){cur.slope[15]}}, cur.slope};
			end
		end
	end

	// newest sample enters the top lane and moves down.
	always_ff @(posedge clk) begin
		if (sample_vld && !step_if.flush) lanes <= {sample, lanes[LANES-1:1]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample_vld  <= 1'b0;
			lane_cnt    <= '0;
			valid_batch <= 1'b0;
		end else begin
			sample_vld  <= step_if.step;
			valid_batch <= sample_vld && !step_if.flush && (lane_cnt == LAST_LANE);
			if (step_if.flush) begin
				lane_cnt <= '0;
			end else if (sample_vld) begin
				lane_cnt <= (lane_cnt == LAST_LANE) ? '0 : lane_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pwl_seg_timer.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

module pwl_seg_timer (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  running,
	input  logic [`PWL_CNT_W-1:0] seg_count,
	pwl_step_if.timer             step_if
);
	import pwl_stream_pkg::*;

	logic [`PWL_LEN_W-1:0] step_cnt;
	logic [`PWL_LEN_W:0]   step_nxt;
	seg_idx_t              seg_idx;
	logic [`PWL_CNT_W-1:0] idx_nxt;
	logic                  seg_end;
	logic                  tab_end;
	logic                  run_d;

	assign step_if.step      = running;
	assign step_if.seg_first = running && (step_cnt == '0);
	assign step_if.seg_idx   = seg_idx;
	assign step_if.flush     = run_d && !running; // first cycle out of run.

	// a zero length still plays one sample.
	assign step_nxt = {1'b0, step_cnt} + 1'b1;
	assign seg_end  = step_nxt >= {1'b0, step_if.seg_len};
	assign idx_nxt  = {1'b0, seg_idx} + 1'b1;
	assign tab_end  = idx_nxt >= seg_count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_cnt <= '0;
			seg_idx  <= '0;
			run_d    <= 1'b0;
		end else begin
			run_d <= running;
			if (!running) begin
				// restart from segment 0 on the next run.
				step_cnt <= '0;
				seg_idx  <= '0;
			end else if (seg_end) begin
				step_cnt <= '0;
				seg_idx  <= tab_end ? '0 : idx_nxt[$bits(seg_idx_t)-1:0];
			end else begin
				step_cnt <= step_nxt[`PWL_LEN_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pwl_step_if.sv
`timescale 1ns/1ps
`include "pwl_consts.svh"
`default_nettype none

interface pwl_step_if;
	import pwl_stream_pkg::*;

	logic                  step;      // one sample this cycle.
	logic                  seg_first;
	seg_idx_t              seg_idx;
	logic                  flush;     // drop partial batch.
	logic [`PWL_LEN_W-1:0] seg_len;

	modport timer (
		output step, seg_first, seg_idx, flush,
		input  seg_len
	);

	modport gen (
		input  step, seg_first, seg_idx, flush,
		output seg_len
	);

endinterface

`default_nettype wire

// File: source/pwl_stream_pkg.sv
`include "pwl_consts.svh"
`default_nettype none

package pwl_stream_pkg;

	typedef logic [`PWL_DMA_W-1:0] dma_word_t;

	// layout of one table entry as it arrives on the stream.
	typedef struct packed {
		logic [15:0]                  rsvd;  // ignored.
		logic [`PWL_LEN_W-1:0]        len;
		logic signed [15:0]           slope; // q8.8.
		logic signed [`PWL_SAMPLE_W-1:0] start;
	} seg_word_t;

	typedef logic [$clog2(`PWL_MAX_SEGS)-1:0] seg_idx_t;

endpackage

`default_nettype wire

// File: source/pwl_wave_pkg.sv
`include "pwl_consts.svh"
`default_nettype none

package pwl_wave_pkg;

	typedef logic signed [`PWL_SAMPLE_W-1:0] sample_t;

	// lane 0 holds the oldest sample.
	typedef sample_t [`PWL_BATCH-1:0] batch_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		READY,
		RUN
	} pwl_state_t;

endpackage

`default_nettype wire
